// ==== logic/lcd_cmd_pkg.sv ====
// ST7735 command set
// opcode values, one init step record and the power-up table walked by the sequencer

`default_nettype none

package lcd_cmd_pkg;

   typedef enum logic [7:0] {
      SWRESET = 8'h01,  // software reset
      SLPOUT  = 8'h11,  // sleep out
      INVCTR  = 8'hB4,  // inversion control
      PWCTR1  = 8'hC0,
      PWCTR4  = 8'hC3,
      PWCTR5  = 8'hC4,
      VMCTR1  = 8'hC5,  // vcom control
      INVON   = 8'h21,
      MADCTL  = 8'h36,  // memory access order
      COLMOD  = 8'h3A,  // pixel format
      CASET   = 8'h2A,  // column window
      RASET   = 8'h2B,  // row window
      NORON   = 8'h13,
      DISPON  = 8'h29,
      RAMWR   = 8'h2C   // start of pixel data
   } lcd_cmd_e;

   // one init step, first parameter byte sits in params[23:16]
   typedef struct packed {
      lcd_cmd_e    opcode;
      logic [1:0]  n_params;  // 0 to 3
      logic [23:0] params;
      logic [8:0]  wait_ms;   // pause after the step, 0 for none
   } init_entry_t;

   localparam int INIT_LEN = 12;

   localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
      '{SWRESET, 2'd0, 24'h000000, 9'd150},
      '{SLPOUT,  2'd0, 24'h000000, 9'd500},
      '{INVCTR,  2'd1, 24'h070000, 9'd0},
      '{PWCTR1,  2'd3, 24'hA20284, 9'd0},
      '{PWCTR4,  2'd2, 24'h8A2A00, 9'd0},
      '{PWCTR5,  2'd2, 24'h8AEE00, 9'd0},
      '{VMCTR1,  2'd1, 24'h0E0000, 9'd0},
      '{INVON,   2'd0, 24'h000000, 9'd0},
      '{MADCTL,  2'd1, 24'hC80000, 9'd0},  // row/col order for this panel
      '{COLMOD,  2'd1, 24'h050000, 9'd0},  // 16 bit rgb565
      '{NORON,   2'd0, 24'h000000, 9'd10},
      '{DISPON,  2'd0, 24'h000000, 9'd100}
   };

endpackage

`default_nettype wire

// ==== logic/lcd_link_pkg.sv ====
// link types between the controller stages
// pixels from the source and words handed to the SPI shifter

`default_nettype none

package lcd_link_pkg;

   // rgb565, red in the top five bits
   typedef logic [15:0] pixel_t;

   // data/command line levels
   localparam logic DC_CMD  = 1'b0;
   localparam logic DC_DATA = 1'b1;

   typedef struct packed {
      logic        dc;       // 0 command, 1 data
      logic        wide;     // 1 for a 16 bit word
      logic [15:0] payload;  // byte words use the low half
   } spi_word_t;

endpackage

`default_nettype wire

// ==== logic/panel_reset_timer.sv ====
// panel hardware reset
// holds lcd_rst_n low for a fixed pulse, then flags the panel ready after a recovery time

`timescale 1ns/1ps
`default_nettype none

module panel_reset_timer #(
   parameter int RESET_LOW_CYCLES  = 120000,
   parameter int RESET_WAIT_CYCLES = 1440000
) (
   input  logic clk,
   input  logic arst_n,
   output logic lcd_rst_n,
   output logic panel_ready
);

   localparam int TOTAL = RESET_LOW_CYCLES + RESET_WAIT_CYCLES;
   localparam int CW    = $clog2(TOTAL + 1);

   logic [CW-1:0] cnt;

   // one counter covers both the pulse and the recovery, frozen once ready
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt         <= '0;
         lcd_rst_n   <= 1'b0;
         panel_ready <= 1'b0;
      end else if (!panel_ready) begin
         cnt <= cnt + 1'b1;
         if (cnt == CW'(RESET_LOW_CYCLES - 1))
            lcd_rst_n <= 1'b1;  // end of reset pulse
         if (cnt == CW'(TOTAL - 1))
            panel_ready <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/pixel_port.sv ====
// pixel input port
// four-phase req/ack from the pixel source into a one-entry buffer,
// drained by valid/ready towards the sequencer

`timescale 1ns/1ps
`default_nettype none

module pixel_port (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 pix_req,
   input  lcd_link_pkg::pixel_t pix_data,
   output logic                 pix_ack,
   output logic                 pix_valid,
   input  logic                 pix_ready,
   output lcd_link_pkg::pixel_t pix_word
);

   typedef enum logic [1:0] {
      WAIT_REQ,
      HOLD_ACK,
      WAIT_DROP
   } hs_state_e;

   hs_state_e state;
   logic      buf_full;
   logic      capture;

   // take a new pixel only into an empty buffer, ack stays low meanwhile
   assign capture   = (state == WAIT_REQ) && pix_req && !buf_full;
   assign pix_ack   = (state == HOLD_ACK);
   assign pix_valid = buf_full;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= WAIT_REQ;
         buf_full <= 1'b0;
      end else begin
         case (state)
            WAIT_REQ:  if (capture) state <= HOLD_ACK;
            HOLD_ACK:  if (!pix_req) state <= WAIT_DROP;  // source released req
            WAIT_DROP: state <= WAIT_REQ;   // ack is low again, a new req may follow
            default:   state <= WAIT_REQ;
         endcase

         if (capture)
            buf_full <= 1'b1;
         else if (pix_valid && pix_ready)
            buf_full <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (capture)
         pix_word <= pix_data;
   end

endmodule

`default_nettype wire

// ==== logic/init_sequencer.sv ====
// panel init and frame sequencer
// walks the power-up table with its waits, sets the drawing window, sends RAMWR
// and then forwards pixels as 16 bit data words, restarting RAMWR every frame

`timescale 1ns/1ps
`default_nettype none

module init_sequencer #(
   parameter int MS_CYCLES     = 12000,
   parameter int SCREEN_WIDTH  = 160,
   parameter int SCREEN_HEIGHT = 80,
   parameter int COL_OFFSET    = 26,
   parameter int ROW_OFFSET    = 1
) (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    panel_ready,
   input  logic                    pix_valid,
   input  lcd_link_pkg::pixel_t    pix_word,
   output logic                    pix_ready,
   input  logic                    busy,
   output logic                    word_valid,
   input  logic                    word_ready,
   output lcd_link_pkg::spi_word_t word,
   output logic                    init_done
);

   localparam int FRAME_PIXELS = SCREEN_WIDTH * SCREEN_HEIGHT;
   localparam int PW = $clog2(FRAME_PIXELS + 1);
   localparam int DW = $clog2(512 * MS_CYCLES + 1);  // longest wait is 511 ms

   localparam logic [15:0] COL_START = 16'(COL_OFFSET);
   localparam logic [15:0] COL_END   = 16'(COL_OFFSET + SCREEN_WIDTH - 1);
   localparam logic [15:0] ROW_START = 16'(ROW_OFFSET);
   localparam logic [15:0] ROW_END   = 16'(ROW_OFFSET + SCREEN_HEIGHT - 1);

   typedef enum logic [2:0] {
      WAIT_PANEL,
      SEND_CMD,
      SEND_PARAM,
      WAIT_DELAY,
      SEND_WINDOW,
      SEND_RAMWR,
      STREAM
   } seq_state_e;

   seq_state_e                state;
   logic [3:0]                idx;      // table step
   logic [1:0]                pidx;     // parameter within the step
   logic [3:0]                win_idx;  // CASET, 4 bytes, RASET, 4 bytes
   logic [DW-1:0]             dly_cnt;
   logic [DW-1:0]             dly_target;
   logic [PW-1:0]             pix_cnt;
   lcd_cmd_pkg::init_entry_t  cur;
   logic [7:0]                win_byte;
   logic                      accept;

   assign cur        = lcd_cmd_pkg::INIT_TABLE[idx];
   assign dly_target = DW'(cur.wait_ms) * DW'(MS_CYCLES);
   assign accept     = word_valid & word_ready;
   assign pix_ready  = (state == STREAM) & word_ready;

   always_comb begin
      case (win_idx)
         4'd0:    win_byte = lcd_cmd_pkg::CASET;
         4'd1:    win_byte = COL_START[15:8];
         4'd2:    win_byte = COL_START[7:0];
         4'd3:    win_byte = COL_END[15:8];
         4'd4:    win_byte = COL_END[7:0];
         4'd5:    win_byte = lcd_cmd_pkg::RASET;
         4'd6:    win_byte = ROW_START[15:8];
         4'd7:    win_byte = ROW_START[7:0];
         4'd8:    win_byte = ROW_END[15:8];
         default: win_byte = ROW_END[7:0];
      endcase
   end

   // word offered to the shifter in each state
   always_comb begin
      word_valid   = 1'b0;
      word.dc      = lcd_link_pkg::DC_CMD;
      word.wide    = 1'b0;
      word.payload = {8'h00, cur.opcode};
      case (state)
         SEND_CMD: word_valid = 1'b1;
         SEND_PARAM: begin
            word_valid   = 1'b1;
            word.dc      = lcd_link_pkg::DC_DATA;
            word.payload = {8'h00, cur.params[8 * (2 - pidx) +: 8]};
         end
         SEND_WINDOW: begin
            word_valid   = 1'b1;
            word.dc      = (win_idx != 4'd0) && (win_idx != 4'd5);  // opcodes at 0 and 5
            word.payload = {8'h00, win_byte};
         end
         SEND_RAMWR: begin
            word_valid   = 1'b1;
            word.payload = {8'h00, lcd_cmd_pkg::RAMWR};
         end
         STREAM: begin
            word_valid   = pix_valid;
            word.dc      = lcd_link_pkg::DC_DATA;
            word.wide    = 1'b1;
            word.payload = pix_word;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= WAIT_PANEL;
         idx       <= '0;
         pidx      <= '0;
         win_idx   <= '0;
         dly_cnt   <= '0;
         pix_cnt   <= '0;
         init_done <= 1'b0;
      end else begin
         case (state)
            WAIT_PANEL: if (panel_ready) state <= SEND_CMD;
            SEND_CMD: begin
               if (accept) begin
                  pidx  <= '0;
                  state <= (cur.n_params != 2'd0) ? SEND_PARAM : WAIT_DELAY;
               end
            end
            SEND_PARAM: begin
               if (accept) begin
                  if (pidx == cur.n_params - 1'b1)
                     state <= WAIT_DELAY;
                  else
                     pidx <= pidx + 1'b1;
               end
            end
            WAIT_DELAY: begin
               // steps without a wait pass straight through
               if (dly_cnt == dly_target) begin
                  dly_cnt <= '0;
                  if (idx == 4'(lcd_cmd_pkg::INIT_LEN - 1)) begin
                     win_idx <= '0;
                     state   <= SEND_WINDOW;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= SEND_CMD;
                  end
               end else if (busy) begin
                  dly_cnt <= '0;  // count only once the opcode is out
               end else begin
                  dly_cnt <= dly_cnt + 1'b1;
               end
            end
            SEND_WINDOW: begin
               if (accept) begin
                  if (win_idx == 4'd9)
                     state <= SEND_RAMWR;
                  else
                     win_idx <= win_idx + 1'b1;
               end
            end
            SEND_RAMWR: begin
               if (accept) begin
                  init_done <= 1'b1;
                  pix_cnt   <= '0;
                  state     <= STREAM;
               end
            end
            STREAM: begin
               if (accept) begin
                  if (pix_cnt == PW'(FRAME_PIXELS - 1))
                     state <= SEND_RAMWR;  // frame complete
                  else
                     pix_cnt <= pix_cnt + 1'b1;
               end
            end
            default: state <= WAIT_PANEL;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/spi_serializer.sv ====
// write-only SPI shifter for the panel
// sends one 8 or 16 bit word MSB first, spi_clk idles high, mosi moves on the
// falling edge, cs framed by one half period on each side

`timescale 1ns/1ps
`default_nettype none

module spi_serializer #(
   parameter int SPI_HALF_PERIOD = 2
) (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    word_valid,
   output logic                    word_ready,
   input  lcd_link_pkg::spi_word_t word,
   output logic                    busy,
   output logic                    spi_clk,
   output logic                    spi_mosi,
   output logic                    spi_dc,
   output logic                    spi_cs
);

   localparam int TW = $clog2(SPI_HALF_PERIOD + 1);
   localparam logic [TW-1:0] TICK_LAST = TW'(SPI_HALF_PERIOD - 1);

   logic [TW-1:0] tick_cnt;
   logic          tick;       // end of a half period
   logic [5:0]    edge_cnt;   // half periods done in this word
   logic [5:0]    last_edge;
   logic [15:0]   shreg;
   logic          wide_q;
   logic          accept;
   logic          fall;

   assign word_ready = ~busy;
   assign accept     = word_valid & word_ready;
   assign tick       = busy & (tick_cnt == TICK_LAST);
   assign last_edge  = wide_q ? 6'd33 : 6'd17;  // 2 * bits + 1
   assign fall       = tick & edge_cnt[0] & (edge_cnt != last_edge);

   // half period 0 lowers cs, odd ones drop the clock, even ones raise it,
   // the final one releases cs
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy     <= 1'b0;
         tick_cnt <= '0;
         edge_cnt <= '0;
         wide_q   <= 1'b0;
         spi_clk  <= 1'b1;
         spi_mosi <= 1'b0;
         spi_dc   <= 1'b0;
         spi_cs   <= 1'b1;
      end else if (accept) begin
         busy     <= 1'b1;
         tick_cnt <= '0;
         edge_cnt <= '0;
         wide_q   <= word.wide;
         spi_dc   <= word.dc;  // settles while cs is still high
      end else if (busy) begin
         tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
         if (tick) begin
            edge_cnt <= edge_cnt + 1'b1;
            if (edge_cnt == 6'd0) begin
               spi_cs <= 1'b0;
            end else if (edge_cnt == last_edge) begin
               spi_cs <= 1'b1;
               busy   <= 1'b0;
            end else if (fall) begin
               spi_clk  <= 1'b0;
               spi_mosi <= shreg[15];
            end else begin
               spi_clk <= 1'b1;  // panel samples here
            end
         end
      end
   end

   // byte words are left aligned so the MSB always leaves from bit 15
   always_ff @(posedge clk) begin
      if (accept)
         shreg <= word.wide ? word.payload : {word.payload[7:0], 8'h00};
      else if (fall)
         shreg <= {shreg[14:0], 1'b0};
   end

endmodule

`default_nettype wire

// ==== logic/st7735_ctrl.sv ====
// ST7735 TFT controller top
// reset timer, pixel port, init/frame sequencer and SPI shifter in a chain

`timescale 1ns/1ps
`default_nettype none

module st7735_ctrl #(
   parameter int SPI_HALF_PERIOD   = 2,
   parameter int MS_CYCLES         = 12000,    // 12 MHz clk
   parameter int RESET_LOW_CYCLES  = 120000,   // 10 ms pulse
   parameter int RESET_WAIT_CYCLES = 1440000,  // 120 ms recovery
   parameter int SCREEN_WIDTH      = 160,
   parameter int SCREEN_HEIGHT     = 80,
   parameter int COL_OFFSET        = 26,
   parameter int ROW_OFFSET        = 1
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 pix_req,
   input  lcd_link_pkg::pixel_t pix_data,
   output logic                 pix_ack,
   output logic                 spi_clk,
   output logic                 spi_mosi,
   output logic                 spi_dc,
   output logic                 spi_cs,
   output logic                 lcd_rst_n,
   output logic                 init_done
);

   logic                    panel_ready;
   logic                    pix_valid;
   logic                    pix_ready;
   lcd_link_pkg::pixel_t    pix_word;
   logic                    word_valid;
   logic                    word_ready;
   lcd_link_pkg::spi_word_t word;
   logic                    busy;

   panel_reset_timer #(
      .RESET_LOW_CYCLES  (RESET_LOW_CYCLES),
      .RESET_WAIT_CYCLES (RESET_WAIT_CYCLES)
   ) panel_reset_timer_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .lcd_rst_n   (lcd_rst_n),
      .panel_ready (panel_ready)
   );

   pixel_port pixel_port_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .pix_req   (pix_req),
      .pix_data  (pix_data),
      .pix_ack   (pix_ack),
      .pix_valid (pix_valid),
      .pix_ready (pix_ready),
      .pix_word  (pix_word)
   );

   init_sequencer #(
      .MS_CYCLES     (MS_CYCLES),
      .SCREEN_WIDTH  (SCREEN_WIDTH),
      .SCREEN_HEIGHT (SCREEN_HEIGHT),
      .COL_OFFSET    (COL_OFFSET),
      .ROW_OFFSET    (ROW_OFFSET)
   ) init_sequencer_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .panel_ready (panel_ready),
      .pix_valid   (pix_valid),
      .pix_word    (pix_word),
      .pix_ready   (pix_ready),
      .busy        (busy),
      .word_valid  (word_valid),
      .word_ready  (word_ready),
      .word        (word),
      .init_done   (init_done)
   );

   spi_serializer #(
      .SPI_HALF_PERIOD (SPI_HALF_PERIOD)
   ) spi_serializer_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .word_valid (word_valid),
      .word_ready (word_ready),
      .word       (word),
      .busy       (busy),
      .spi_clk    (spi_clk),
      .spi_mosi   (spi_mosi),
      .spi_dc     (spi_dc),
      .spi_cs     (spi_cs)
   );

endmodule

`default_nettype wire

// ==== tests/tb_st7735_ctrl.sv ====
// testbench for the ST7735 controller
// replays the expected SPI byte stream from the stim file, feeds the pixels
// through the req/ack port and checks reset, waits, window and both frames

`timescale 1ns/1ps
`default_nettype none

module tb_st7735_ctrl;

   localparam int MS_CYCLES  = 2;
   localparam int RESET_LOW  = 20;
   localparam int MAX_RECS   = 64;
   localparam int INIT_END   = 23;     // records up to DISPON
   localparam int WINDOW_END = 34;     // CASET, RASET, first RAMWR
   localparam int FRAME1_END = 40;
   localparam int N_RECS     = 47;
   localparam int WAIT_LIMIT = 20000;  // cycles per wait

   // record types in the stim file
   localparam logic [3:0] REC_CMD  = 4'h1;
   localparam logic [3:0] REC_DATA = 4'h2;
   localparam logic [3:0] REC_PIX  = 4'h3;

   logic                 clk;
   logic                 arst_n;
   logic                 pix_req;
   lcd_link_pkg::pixel_t pix_data;
   logic                 pix_ack;
   logic                 spi_clk;
   logic                 spi_mosi;
   logic                 spi_dc;
   logic                 spi_cs;
   logic                 lcd_rst_n;
   logic                 init_done;

   logic [19:0] stim [MAX_RECS];
   int          n_recs;
   int          rec_idx;       // next expected record
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   int          test_err0;     // error count when the current test began
   logic        timed_out;
   logic        drv_timeout;
   logic [31:0] rng;

   st7735_ctrl #(
      .SPI_HALF_PERIOD   (2),
      .MS_CYCLES         (MS_CYCLES),
      .RESET_LOW_CYCLES  (RESET_LOW),
      .RESET_WAIT_CYCLES (30),
      .SCREEN_WIDTH      (3),
      .SCREEN_HEIGHT     (2),
      .COL_OFFSET        (26),
      .ROW_OFFSET        (1)
   ) st7735_ctrl_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .pix_req   (pix_req),
      .pix_data  (pix_data),
      .pix_ack   (pix_ack),
      .spi_clk   (spi_clk),
      .spi_mosi  (spi_mosi),
      .spi_dc    (spi_dc),
      .spi_cs    (spi_cs),
      .lcd_rst_n (lcd_rst_n),
      .init_done (init_done)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // pause the panel needs after a command, in ms
   function automatic int wait_ms_for(input logic [7:0] opcode);
      case (opcode)
         8'h01:   return 150;  // SWRESET
         8'h11:   return 500;  // SLPOUT
         8'h13:   return 10;   // NORON
         8'h29:   return 100;  // DISPON
         default: return 0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == test_err0) begin
         $display("test %-26s ok", name);
      end else begin
         tests_failed++;
         $display("test %-26s failed with %0d errors", name, errors - test_err0);
      end
      test_err0 = errors;
   endtask

   // compare one received byte with the next expected record
   task automatic score_byte(input logic [7:0] b, input logic dc, input logic moved,
                             inout logic half, inout int need_gap);
      logic [19:0] rec;
      logic [7:0]  exp_byte;
      logic        exp_dc;
      rec      = stim[rec_idx];
      exp_dc   = (rec[19:16] != REC_CMD);
      exp_byte = rec[7:0];
      if (rec[19:16] == REC_PIX && !half)
         exp_byte = rec[15:8];  // high byte first
      check_value("spi byte", 32'(b), 32'(exp_byte));
      check_value("spi_dc", 32'(dc), 32'(exp_dc));
      check_value("spi_dc change within byte", 32'(moved), 32'd0);
      if (rec[19:16] == REC_PIX)
         check_value("init_done", 32'(init_done), 32'd1);
      if (rec[19:16] == REC_CMD)
         need_gap = wait_ms_for(rec[7:0]) * MS_CYCLES;
      if (rec[19:16] == REC_PIX && !half) begin
         half = 1'b1;
      end else begin
         half = 1'b0;
         rec_idx++;
      end
   endtask

   task automatic monitor_spi();
      logic       prev_clk;
      logic       prev_cs;
      logic       prev_ack;
      logic [7:0] shift;
      logic       dc_first;
      logic       dc_moved;
      logic       half;
      int         nbits;
      int         gap;       // cycles with cs high
      int         need_gap;
      prev_clk = 1'b1;
      prev_cs  = 1'b1;
      prev_ack = 1'b0;
      shift    = '0;
      dc_first = 1'b0;
      dc_moved = 1'b0;
      half     = 1'b0;
      nbits    = 0;
      gap      = 0;
      need_gap = 0;
      while (rec_idx < n_recs && !timed_out) begin
         @(posedge clk);
         if (prev_cs && !spi_cs) begin
            check_value("lcd_rst_n at cs low", 32'(lcd_rst_n), 32'd1);
            if (need_gap > 0)
               check_value("cs high gap long enough", 32'(gap >= need_gap), 32'd1);
            need_gap = 0;
            nbits    = 0;
         end
         gap = spi_cs ? gap + 1 : 0;
         // four-phase rule, ack moves only after req
         if (!prev_ack && pix_ack)
            check_value("pix_req at ack rise", 32'(pix_req), 32'd1);
         if (prev_ack && !pix_ack)
            check_value("pix_req at ack fall", 32'(pix_req), 32'd0);
         if (!prev_clk && spi_clk && !spi_cs) begin
            if (nbits % 8 == 0) begin
               dc_first = spi_dc;
               dc_moved = 1'b0;
            end else if (spi_dc != dc_first) begin
               dc_moved = 1'b1;
            end
            shift = {shift[6:0], spi_mosi};
            nbits++;
            if (nbits % 8 == 0)
               score_byte(shift, dc_first, dc_moved, half, need_gap);
         end
         prev_clk = spi_clk;
         prev_cs  = spi_cs;
         prev_ack = pix_ack;
      end
   endtask

   task automatic drive_pixels();
      int n;
      int gap;
      for (int i = 0; i < n_recs && !drv_timeout; i++) begin
         if (stim[i][19:16] == REC_PIX) begin
            rng = next_random(rng);
            gap = int'(rng % 32'd48);  // idle cycles before the request
            repeat (gap) @(posedge clk);
            #2;
            pix_data = stim[i][15:0];
            pix_req  = 1'b1;
            n = 0;
            do begin
               @(posedge clk);
               n++;
            end while (!pix_ack && n < WAIT_LIMIT);
            if (!pix_ack) begin
               $display("pixel record %0d: pix_ack never rose after the request", i);
               drv_timeout = 1'b1;
            end
            #2 pix_req = 1'b0;
            n = 0;
            while (pix_ack && n < WAIT_LIMIT) begin
               @(posedge clk);
               n++;
            end
            if (pix_ack) begin
               $display("pixel record %0d: pix_ack never completed its handshake", i);
               drv_timeout = 1'b1;
            end
         end
      end
   endtask

   task automatic wait_records(input int target);
      int n;
      n = 0;
      while (rec_idx < target && n < WAIT_LIMIT && !timed_out && !drv_timeout) begin
         @(posedge clk);
         n++;
      end
      if (rec_idx < target && !timed_out) begin
         $display("timeout: SPI stream stopped at record %0d, waiting for %0d", rec_idx, target);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   initial begin
      int n;
      arst_n       = 1'b0;
      pix_req      = 1'b0;
      pix_data     = '0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_err0    = 0;
      rec_idx      = 0;
      timed_out    = 1'b0;
      drv_timeout  = 1'b0;
      rng          = 32'd51993;
      foreach (stim[i])
         stim[i] = '0;
      $readmemh("tests/st7735_stim.txt", stim);
      n_recs = 0;
      while (n_recs < MAX_RECS && stim[n_recs][19:16] != 4'h0)
         n_recs++;
      check_value("stim record count", 32'(n_recs), 32'(N_RECS));

      repeat (4) @(posedge clk);
      check_value("spi_cs", 32'(spi_cs), 32'd1);
      check_value("spi_clk", 32'(spi_clk), 32'd1);
      check_value("spi_dc", 32'(spi_dc), 32'd0);
      check_value("spi_mosi", 32'(spi_mosi), 32'd0);
      check_value("lcd_rst_n", 32'(lcd_rst_n), 32'd0);
      check_value("pix_ack", 32'(pix_ack), 32'd0);
      check_value("init_done", 32'(init_done), 32'd0);
      #2 arst_n = 1'b1;
      fork
         monitor_spi();
         drive_pixels();
      join_none

      n = 0;
      while (!lcd_rst_n && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (!lcd_rst_n) begin
         $display("timeout: lcd_rst_n never left reset");
         errors++;
         timed_out = 1'b1;
      end else begin
         // the first high sample comes one edge after the rise
         check_value("lcd_rst_n low cycles", 32'(n), 32'(RESET_LOW + 1));
         check_value("spi_cs at lcd_rst_n rise", 32'(spi_cs), 32'd1);
      end
      finish_test("reset and lcd_rst_n");

      wait_records(INIT_END);
      finish_test("init command stream");
      wait_records(WINDOW_END);
      finish_test("window and RAMWR");
      wait_records(FRAME1_END);
      finish_test("first frame pixels");
      wait_records(N_RECS);
      finish_test("RAMWR and second frame");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0 && !timed_out && !drv_timeout)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/st7735_stim.txt ====
// one record per word, type digit then 16 bit value: 1 command byte, 2 data byte,
// 3 pixel sent by the driver and expected back as two data bytes, high byte first
10001
10011
100B4 20007
100C0 200A2 20002 20084
100C3 2008A 2002A
100C4 2008A 200EE
100C5 2000E
10021
10036 200C8
1003A 20005
10013
10029
1002A 20000 2001A 20000 2001C
1002B 20000 20001 20000 20002
1002C
3F800 307E0 3001F 3FFFF 30000 3A5C3
1002C
38410 31234 3FEDC 30F0F 3F0F0 35AA5

// ==== sim.f ====
logic/lcd_cmd_pkg.sv
logic/lcd_link_pkg.sv
logic/panel_reset_timer.sv
logic/pixel_port.sv
logic/init_sequencer.sv
logic/spi_serializer.sv
logic/st7735_ctrl.sv
tests/tb_st7735_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the ST7735 controller testbench with Verilator and runs it
# exit status 0 only when the pass line appears in the output

cd "$(dirname "$0")" || exit 1

out="$(verilator --binary --timing --top-module tb_st7735_ctrl -f sim.f \
   -o tb_st7735_ctrl 2>&1 && ./obj_dir/tb_st7735_ctrl 2>&1)"

echo "$out"

echo "$out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
